/* design/cache_pkg.sv */
// cache geometry, address field positions and miss state encodings
`default_nettype none

package cache_pkg;

  // address and word
  localparam int addr_width = 16;
  localparam int data_width = 32;

  // set-associative geometry
  localparam int ways = 4;
  localparam int lg_ways = 2;
  localparam int sets = 16;
  localparam int lg_sets = 4;
  localparam int block_words = 4;
  localparam int lg_block_words = 2;
  localparam int byte_offset_width = 2;
  localparam int tag_width = addr_width - lg_sets - lg_block_words - byte_offset_width;

  // tree bits per set
  localparam int lru_width = ways - 1;

  // address layout from the low end is byte, word, index, tag
  localparam int word_lsb = byte_offset_width;
  localparam int index_lsb = word_lsb + lg_block_words;
  localparam int tag_lsb = index_lsb + lg_sets;

  // miss unit states
  localparam int miss_state_width = 3;
  localparam logic [miss_state_width-1:0] miss_idle = 3'd0;
  localparam logic [miss_state_width-1:0] miss_evict_req = 3'd1;
  localparam logic [miss_state_width-1:0] miss_evict_data = 3'd2;
  localparam logic [miss_state_width-1:0] miss_fill_req = 3'd3;
  localparam logic [miss_state_width-1:0] miss_fill_data = 3'd4;
  localparam logic [miss_state_width-1:0] miss_recover = 3'd5;

endpackage

`default_nettype wire

/* design/cache_way.sv */
// valid, dirty, tag and data arrays of one way with synchronous read and tag compare
`timescale 1ns/1ps
`default_nettype none

module cache_way (
  input  wire                                  clk_i,
  input  wire                                  reset_i,
  input  wire                                  rd_i,
  input  wire  [cache_pkg::lg_sets-1:0]        index_i,
  input  wire  [cache_pkg::lg_block_words-1:0] word_i,
  input  wire  [cache_pkg::tag_width-1:0]      req_tag_i,
  input  wire                                  tag_we_i,
  input  wire  [cache_pkg::tag_width-1:0]      new_tag_i,
  input  wire                                  data_we_i,
  input  wire  [cache_pkg::data_width-1:0]     wdata_i,
  input  wire                                  dirty_we_i,
  input  wire                                  dirty_i,
  output logic                                 hit_o,
  output logic                                 valid_o,
  output logic                                 dirty_o,
  output logic [cache_pkg::tag_width-1:0]      tag_o,
  output logic [cache_pkg::data_width-1:0]     rdata_o
);
  import cache_pkg::*;

  logic [sets-1:0] valid_r;
  logic [sets-1:0] dirty_r;
  logic [tag_width-1:0] tag_mem [sets];
  logic [data_width-1:0] data_mem [sets*block_words];

  // a tag write installs a clean block
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
      dirty_r <= '0;
    end else if (tag_we_i) begin
      valid_r[index_i] <= 1'b1;
      dirty_r[index_i] <= 1'b0;
    end else if (dirty_we_i) begin
      dirty_r[index_i] <= dirty_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tag_we_i) begin
      tag_mem[index_i] <= new_tag_i;
    end
    if (data_we_i) begin
      data_mem[{index_i, word_i}] <= wdata_i;
    end
  end

  // the read result shows up the cycle after the strobe
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else if (rd_i) begin
      valid_o <= valid_r[index_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      dirty_o <= dirty_r[index_i];
      tag_o <= tag_mem[index_i];
      rdata_o <= data_mem[{index_i, word_i}];
    end
  end

  assign hit_o = valid_o & (tag_o == req_tag_i);

endmodule

`default_nettype wire

/* design/cache_req_stage.sv */
// request register, client handshakes and per-way read and write drive
`timescale 1ns/1ps
`default_nettype none

module cache_req_stage (
  input  wire                                  clk_i,
  input  wire                                  reset_i,
  input  wire                                  v_i,
  input  wire                                  we_i,
  input  wire  [cache_pkg::addr_width-1:0]     addr_i,
  input  wire  [cache_pkg::data_width-1:0]     wdata_i,
  input  wire                                  yumi_i,
  input  wire                                  hit_found_i,
  input  wire  [cache_pkg::lg_ways-1:0]        hit_way_i,
  input  wire                                  miss_busy_i,
  input  wire                                  mem_rd_i,
  input  wire  [cache_pkg::lg_block_words-1:0] mem_word_i,
  input  wire                                  fill_we_i,
  input  wire  [cache_pkg::lg_block_words-1:0] fill_word_i,
  input  wire  [cache_pkg::data_width-1:0]     fill_data_i,
  input  wire                                  fill_tag_we_i,
  input  wire  [cache_pkg::lg_ways-1:0]        fill_way_i,
  output logic                                 ready_o,
  output logic                                 v_o,
  output logic                                 req_we_o,
  output logic [cache_pkg::addr_width-1:0]     req_addr_o,
  output logic [cache_pkg::data_width-1:0]     req_wdata_o,
  output logic                                 way_rd_o,
  output logic [cache_pkg::lg_sets-1:0]        way_index_o,
  output logic [cache_pkg::lg_block_words-1:0] way_word_o,
  output logic [cache_pkg::ways-1:0]           way_tag_we_o,
  output logic [cache_pkg::ways-1:0]           way_data_we_o,
  output logic [cache_pkg::ways-1:0]           way_dirty_we_o,
  output logic [cache_pkg::data_width-1:0]     way_wdata_o,
  output logic                                 held_o
);
  import cache_pkg::*;

  logic v_r;
  logic accept;
  logic store_done;

  assign accept = v_i & ready_o;
  assign ready_o = ~v_r;
  // a response waits until the miss unit has finished its re-read
  assign v_o = v_r & hit_found_i & ~miss_busy_i;
  assign store_done = v_o & yumi_i & req_we_o;
  assign held_o = v_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r <= 1'b0;
    end else if (accept) begin
      v_r <= 1'b1;
    end else if (v_o & yumi_i) begin
      v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_we_o <= we_i;
      req_addr_o <= addr_i;
      req_wdata_o <= wdata_i;
    end
  end

  assign way_rd_o = accept | mem_rd_i;
  assign way_index_o = v_r ? req_addr_o[index_lsb +: lg_sets] : addr_i[index_lsb +: lg_sets];
  assign way_wdata_o = fill_we_i ? fill_data_i : req_wdata_o;

  always_comb begin
    if (!v_r) begin
      way_word_o = addr_i[word_lsb +: lg_block_words];
    end else if (mem_rd_i) begin
      way_word_o = mem_word_i;
    end else if (fill_we_i) begin
      way_word_o = fill_word_i;
    end else begin
      way_word_o = req_addr_o[word_lsb +: lg_block_words];
    end
  end

  // store hits and fills never overlap so the strobes stay one-hot
  always_comb begin
    for (int w = 0; w < ways; w++) begin
      way_dirty_we_o[w] = store_done & (hit_way_i == lg_ways'(w));
      way_data_we_o[w] = way_dirty_we_o[w] | (fill_we_i & (fill_way_i == lg_ways'(w)));
      way_tag_we_o[w] = fill_tag_we_i & (fill_way_i == lg_ways'(w));
    end
  end

endmodule

`default_nettype wire

/* design/cache_hit_select.sv */
// hit encode, load word mux, victim choice and per-set tree LRU bits
`timescale 1ns/1ps
`default_nettype none

module cache_hit_select (
  input  wire                                                      clk_i,
  input  wire                                                      reset_i,
  input  wire  [cache_pkg::ways-1:0]                               hit_i,
  input  wire  [cache_pkg::ways-1:0]                               valid_i,
  input  wire  [cache_pkg::ways-1:0]                               dirty_i,
  input  wire  [cache_pkg::ways-1:0][cache_pkg::tag_width-1:0]     tag_i,
  input  wire  [cache_pkg::ways-1:0][cache_pkg::data_width-1:0]    rdata_i,
  input  wire  [cache_pkg::lg_sets-1:0]                            req_index_i,
  input  wire                                                      done_i,
  output logic                                                     hit_found_o,
  output logic [cache_pkg::lg_ways-1:0]                            hit_way_o,
  output logic [cache_pkg::data_width-1:0]                         data_o,
  output logic [cache_pkg::lg_ways-1:0]                            victim_way_o,
  output logic                                                     victim_dirty_o,
  output logic [cache_pkg::tag_width-1:0]                          victim_tag_o,
  output logic [cache_pkg::data_width-1:0]                         victim_data_o
);
  import cache_pkg::*;

  logic [lru_width-1:0] lru_r [sets];
  logic [lru_width-1:0] lru_set;
  logic [lg_ways-1:0] lru_way;
  logic invalid_found;
  logic [lg_ways-1:0] invalid_way;

  // lowest way wins in both encoders
  always_comb begin
    hit_found_o = 1'b0;
    hit_way_o = '0;
    invalid_found = 1'b0;
    invalid_way = '0;
    for (int w = ways - 1; w >= 0; w--) begin
      if (hit_i[w]) begin
        hit_found_o = 1'b1;
        hit_way_o = lg_ways'(w);
      end
      if (!valid_i[w]) begin
        invalid_found = 1'b1;
        invalid_way = lg_ways'(w);
      end
    end
  end

  assign data_o = rdata_i[hit_way_o];

  // root bit picks the half and the leaf bit picks the way inside it
  assign lru_set = lru_r[req_index_i];
  assign lru_way = lru_set[0] ? {1'b1, lru_set[2]} : {1'b0, lru_set[1]};

  assign victim_way_o = invalid_found ? invalid_way : lru_way;
  assign victim_dirty_o = valid_i[victim_way_o] & dirty_i[victim_way_o];
  assign victim_tag_o = tag_i[victim_way_o];
  assign victim_data_o = rdata_i[victim_way_o];

  // point every node on the used path away from the used way
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets; s++) begin
        lru_r[s] <= '0;
      end
    end else if (done_i) begin
      lru_r[req_index_i][0] <= ~hit_way_o[1];
      if (hit_way_o[1]) begin
        lru_r[req_index_i][2] <= ~hit_way_o[0];
      end else begin
        lru_r[req_index_i][1] <= ~hit_way_o[0];
      end
    end
  end

endmodule

`default_nettype wire

/* design/cache_miss_dma.sv */
// miss FSM sequencing writeback, block fill and the recover re-read
`timescale 1ns/1ps
`default_nettype none

module cache_miss_dma (
  input  wire                                  clk_i,
  input  wire                                  reset_i,
  input  wire                                  held_i,
  input  wire                                  hit_found_i,
  input  wire  [cache_pkg::addr_width-1:0]     req_addr_i,
  input  wire  [cache_pkg::lg_ways-1:0]        victim_way_i,
  input  wire                                  victim_dirty_i,
  input  wire  [cache_pkg::tag_width-1:0]      victim_tag_i,
  input  wire  [cache_pkg::data_width-1:0]     victim_data_i,
  input  wire                                  dma_req_yumi_i,
  input  wire  [cache_pkg::data_width-1:0]     dma_data_i,
  input  wire                                  dma_data_v_i,
  output logic                                 miss_busy_o,
  output logic                                 mem_rd_o,
  output logic [cache_pkg::lg_block_words-1:0] mem_word_o,
  output logic                                 fill_we_o,
  output logic [cache_pkg::lg_block_words-1:0] fill_word_o,
  output logic [cache_pkg::data_width-1:0]     fill_data_o,
  output logic                                 fill_tag_we_o,
  output logic [cache_pkg::lg_ways-1:0]        fill_way_o,
  output logic                                 dma_req_v_o,
  output logic                                 dma_req_write_o,
  output logic [cache_pkg::addr_width-1:0]     dma_req_addr_o,
  output logic [cache_pkg::data_width-1:0]     dma_data_o,
  output logic                                 dma_data_v_o
);
  import cache_pkg::*;

  logic [miss_state_width-1:0] state_r;
  logic [lg_block_words-1:0] cnt_r;
  logic [lg_ways-1:0] way_r;
  logic [tag_width-1:0] victim_tag_r;
  logic [lg_sets-1:0] req_index;
  logic miss_start;
  logic last_beat;

  assign req_index = req_addr_i[index_lsb +: lg_sets];
  assign miss_start = (state_r == miss_idle) & held_i & ~hit_found_i;
  assign last_beat = (cnt_r == lg_block_words'(block_words - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= miss_idle;
      cnt_r <= '0;
    end else begin
      case (state_r)
        miss_idle: begin
          cnt_r <= '0;
          if (miss_start) begin
            // a clean victim skips the writeback
            state_r <= victim_dirty_i ? miss_evict_req : miss_fill_req;
          end
        end
        miss_evict_req: begin
          if (dma_req_yumi_i) begin
            state_r <= miss_evict_data;
          end
        end
        miss_evict_data: begin
          cnt_r <= cnt_r + 1'b1;
          if (last_beat) begin
            state_r <= miss_fill_req;
          end
        end
        miss_fill_req: begin
          if (dma_req_yumi_i) begin
            state_r <= miss_fill_data;
          end
        end
        miss_fill_data: begin
          if (dma_data_v_i) begin
            cnt_r <= cnt_r + 1'b1;
            if (last_beat) begin
              state_r <= miss_recover;
            end
          end
        end
        default: begin
          state_r <= miss_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss_start) begin
      way_r <= victim_way_i;
      victim_tag_r <= victim_tag_i;
    end
  end

  assign miss_busy_o = (state_r != miss_idle);

  // evict reads run one word ahead of the beat on the bus
  assign mem_rd_o = (state_r == miss_evict_req) | (state_r == miss_evict_data)
                  | (state_r == miss_recover);
  always_comb begin
    if (state_r == miss_recover) begin
      mem_word_o = req_addr_i[word_lsb +: lg_block_words];
    end else if (state_r == miss_evict_data) begin
      mem_word_o = cnt_r + 1'b1;
    end else begin
      mem_word_o = '0;
    end
  end

  assign fill_we_o = (state_r == miss_fill_data) & dma_data_v_i;
  assign fill_word_o = cnt_r;
  assign fill_data_o = dma_data_i;
  assign fill_tag_we_o = fill_we_o & last_beat;
  assign fill_way_o = way_r;

  assign dma_req_v_o = (state_r == miss_evict_req) | (state_r == miss_fill_req);
  assign dma_req_write_o = (state_r == miss_evict_req);
  assign dma_req_addr_o = dma_req_write_o
                        ? {victim_tag_r, req_index, {index_lsb{1'b0}}}
                        : {req_addr_i[tag_lsb +: tag_width], req_index, {index_lsb{1'b0}}};
  assign dma_data_o = victim_data_i;
  assign dma_data_v_o = (state_r == miss_evict_data);

endmodule

`default_nettype wire

/* design/cache_top.sv */
// request stage, four ways, hit selector and miss unit of the data cache
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input  wire                              clk_i,
  input  wire                              reset_i,
  input  wire                              v_i,
  input  wire                              we_i,
  input  wire  [cache_pkg::addr_width-1:0] addr_i,
  input  wire  [cache_pkg::data_width-1:0] wdata_i,
  output logic                             ready_o,
  output logic                             v_o,
  output logic [cache_pkg::data_width-1:0] data_o,
  input  wire                              yumi_i,
  output logic                             dma_req_v_o,
  output logic                             dma_req_write_o,
  output logic [cache_pkg::addr_width-1:0] dma_req_addr_o,
  input  wire                              dma_req_yumi_i,
  input  wire  [cache_pkg::data_width-1:0] dma_data_i,
  input  wire                              dma_data_v_i,
  output logic [cache_pkg::data_width-1:0] dma_data_o,
  output logic                             dma_data_v_o
);
  import cache_pkg::*;

  logic req_we;
  logic [addr_width-1:0] req_addr;
  logic [tag_width-1:0] req_tag;
  logic held;
  logic way_rd;
  logic [lg_sets-1:0] way_index;
  logic [lg_block_words-1:0] way_word;
  logic [ways-1:0] way_tag_we;
  logic [ways-1:0] way_data_we;
  logic [ways-1:0] way_dirty_we;
  logic [data_width-1:0] way_wdata;

  logic [ways-1:0] hit;
  logic [ways-1:0] valid;
  logic [ways-1:0] dirty;
  logic [ways-1:0][tag_width-1:0] tag;
  logic [ways-1:0][data_width-1:0] rdata;

  logic hit_found;
  logic [lg_ways-1:0] hit_way;
  logic [data_width-1:0] hit_data;
  logic [lg_ways-1:0] victim_way;
  logic victim_dirty;
  logic [tag_width-1:0] victim_tag;
  logic [data_width-1:0] victim_data;

  logic miss_busy;
  logic mem_rd;
  logic [lg_block_words-1:0] mem_word;
  logic fill_we;
  logic [lg_block_words-1:0] fill_word;
  logic [data_width-1:0] fill_data;
  logic fill_tag_we;
  logic [lg_ways-1:0] fill_way;

  assign req_tag = req_addr[tag_lsb +: tag_width];
  // stores answer with zero
  assign data_o = req_we ? '0 : hit_data;

  cache_req_stage stage (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(v_i), .we_i(we_i), .addr_i(addr_i), .wdata_i(wdata_i), .yumi_i(yumi_i),
    .hit_found_i(hit_found), .hit_way_i(hit_way), .miss_busy_i(miss_busy),
    .mem_rd_i(mem_rd), .mem_word_i(mem_word),
    .fill_we_i(fill_we), .fill_word_i(fill_word), .fill_data_i(fill_data),
    .fill_tag_we_i(fill_tag_we), .fill_way_i(fill_way),
    .ready_o(ready_o), .v_o(v_o),
    .req_we_o(req_we), .req_addr_o(req_addr), .req_wdata_o(),
    .way_rd_o(way_rd), .way_index_o(way_index), .way_word_o(way_word),
    .way_tag_we_o(way_tag_we), .way_data_we_o(way_data_we),
    .way_dirty_we_o(way_dirty_we), .way_wdata_o(way_wdata), .held_o(held)
  );

  for (genvar w = 0; w < ways; w++) begin : g_way
    // a dirty write only comes from a store hit
    cache_way way (
      .clk_i(clk_i), .reset_i(reset_i),
      .rd_i(way_rd), .index_i(way_index), .word_i(way_word), .req_tag_i(req_tag),
      .tag_we_i(way_tag_we[w]), .new_tag_i(req_tag),
      .data_we_i(way_data_we[w]), .wdata_i(way_wdata),
      .dirty_we_i(way_dirty_we[w]), .dirty_i(1'b1),
      .hit_o(hit[w]), .valid_o(valid[w]), .dirty_o(dirty[w]),
      .tag_o(tag[w]), .rdata_o(rdata[w])
    );
  end

  cache_hit_select sel (
    .clk_i(clk_i), .reset_i(reset_i),
    .hit_i(hit), .valid_i(valid), .dirty_i(dirty), .tag_i(tag), .rdata_i(rdata),
    .req_index_i(req_addr[index_lsb +: lg_sets]), .done_i(v_o & yumi_i),
    .hit_found_o(hit_found), .hit_way_o(hit_way), .data_o(hit_data),
    .victim_way_o(victim_way), .victim_dirty_o(victim_dirty),
    .victim_tag_o(victim_tag), .victim_data_o(victim_data)
  );

  cache_miss_dma miss (
    .clk_i(clk_i), .reset_i(reset_i),
    .held_i(held), .hit_found_i(hit_found), .req_addr_i(req_addr),
    .victim_way_i(victim_way), .victim_dirty_i(victim_dirty),
    .victim_tag_i(victim_tag), .victim_data_i(victim_data),
    .dma_req_yumi_i(dma_req_yumi_i), .dma_data_i(dma_data_i), .dma_data_v_i(dma_data_v_i),
    .miss_busy_o(miss_busy), .mem_rd_o(mem_rd), .mem_word_o(mem_word),
    .fill_we_o(fill_we), .fill_word_o(fill_word), .fill_data_o(fill_data),
    .fill_tag_we_o(fill_tag_we), .fill_way_o(fill_way),
    .dma_req_v_o(dma_req_v_o), .dma_req_write_o(dma_req_write_o),
    .dma_req_addr_o(dma_req_addr_o),
    .dma_data_o(dma_data_o), .dma_data_v_o(dma_data_v_o)
  );

endmodule

`default_nettype wire

/* sim/tb_cache.sv */
// clock, reset, block memory model, file-driven accesses and response checks
`timescale 1ns/1ps
`default_nettype none

module tb_cache;
  import cache_pkg::*;

  localparam int timeout_cycles = 200;
  localparam int mem_words = 2 ** (addr_width - 2);

  logic clk_i;
  logic reset_i;
  logic v_i;
  logic we_i;
  logic [addr_width-1:0] addr_i;
  logic [data_width-1:0] wdata_i;
  logic ready_o;
  logic v_o;
  logic [data_width-1:0] data_o;
  logic yumi_i;
  logic dma_req_v_o;
  logic dma_req_write_o;
  logic [addr_width-1:0] dma_req_addr_o;
  logic dma_req_yumi_i;
  logic [data_width-1:0] dma_data_i;
  logic dma_data_v_i;
  logic [data_width-1:0] dma_data_o;
  logic dma_data_v_o;

  // memory model state
  logic [data_width-1:0] mem [mem_words];
  logic mem_write;
  logic [addr_width-1:0] mem_addr;
  logic [addr_width-1:0] last_read_addr;
  logic [addr_width-1:0] last_write_addr;
  int evict_left;
  int fill_left;
  int read_reqs;
  int write_reqs;

  integer seed;
  integer fd;
  int tests;
  int failed;
  int errors;
  logic timed_out;
  logic [8*128-1:0] line;
  logic [31:0] f_op;
  logic [31:0] f_miss;
  logic [31:0] f_addr;
  logic [31:0] f_wdata;
  logic [31:0] f_rdata;
  logic [31:0] f_wb;

  cache_top DUT (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(v_i), .we_i(we_i), .addr_i(addr_i), .wdata_i(wdata_i),
    .ready_o(ready_o), .v_o(v_o), .data_o(data_o), .yumi_i(yumi_i),
    .dma_req_v_o(dma_req_v_o), .dma_req_write_o(dma_req_write_o),
    .dma_req_addr_o(dma_req_addr_o), .dma_req_yumi_i(dma_req_yumi_i),
    .dma_data_i(dma_data_i), .dma_data_v_i(dma_data_v_i),
    .dma_data_o(dma_data_o), .dma_data_v_o(dma_data_v_o)
  );

  always #4 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
      errors++;
    end
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!ready_o && !timed_out) begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (cycles > timeout_cycles) begin
        $display("timeout: ready_o stayed low for %0d cycles", timeout_cycles);
        timed_out = 1'b1;
        errors++;
      end
    end
  endtask

  task automatic wait_response(output int cycles);
    cycles = 0;
    while (!v_o && !timed_out) begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (cycles > timeout_cycles) begin
        $display("timeout: no response on v_o within %0d cycles", timeout_cycles);
        timed_out = 1'b1;
        errors++;
      end
    end
  endtask

  // issues one client access and checks its memory traffic against the expected columns
  task automatic run_access(input logic [31:0] op, input logic [31:0] miss,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [31:0] rdata, input logic [31:0] wb_addr);
    int errors_before;
    int reads_before;
    int writes_before;
    int cycles;
    int delay;
    logic [data_width-1:0] resp_data;
    errors_before = errors;
    tests++;
    wait_ready();
    reads_before = read_reqs;
    writes_before = write_reqs;
    if (!timed_out) begin
      v_i = 1'b1;
      we_i = op[0];
      addr_i = addr[addr_width-1:0];
      wdata_i = wdata;
      @(posedge clk_i);
      #1;
      v_i = 1'b0;
      we_i = 1'b0;
      wait_response(cycles);
    end
    if (!timed_out) begin
      resp_data = data_o;
      check_value("data_o", resp_data, rdata);
      if (miss == 0) begin
        check_value("hit latency", cycles, 0);
      end
      // response holds while yumi_i stays low
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) begin
        @(posedge clk_i);
        #1;
        check_value("v_o", v_o, 1);
        check_value("data_o", data_o, resp_data);
      end
      yumi_i = 1'b1;
      @(posedge clk_i);
      #1;
      yumi_i = 1'b0;
      check_value("ready_o", ready_o, 1);
      if (miss != 0) begin
        check_value("read requests", read_reqs - reads_before, 1);
        check_value("dma_req_addr_o", last_read_addr, addr & ~32'hf);
      end else begin
        check_value("read requests", read_reqs - reads_before, 0);
      end
      if (wb_addr[15:0] != 16'hffff) begin
        check_value("write requests", write_reqs - writes_before, 1);
        check_value("dma_req_addr_o", last_write_addr, wb_addr);
      end else begin
        check_value("write requests", write_reqs - writes_before, 0);
      end
    end
    if (errors == errors_before) begin
      $display("test %0d: %s %h ok", tests, op[0] ? "store" : "load", addr[15:0]);
    end else begin
      failed++;
      $display("test %0d: %s %h FAILED", tests, op[0] ? "store" : "load", addr[15:0]);
    end
  endtask

  // memory model answers one request at a time and takes every evict beat
  always @(posedge clk_i) begin
    #1;
    if (dma_req_yumi_i) begin
      if (mem_write) begin
        evict_left = block_words;
        write_reqs++;
        last_write_addr = mem_addr;
      end else begin
        fill_left = block_words;
        read_reqs++;
        last_read_addr = mem_addr;
      end
    end
    dma_req_yumi_i = 1'b0;
    dma_data_v_i = 1'b0;
    if (evict_left > 0) begin
      check_value("dma_data_v_o", dma_data_v_o, 1);
      mem[mem_addr[addr_width-1:2] + block_words - evict_left] = dma_data_o;
      evict_left--;
    end else if (fill_left > 0) begin
      dma_data_v_i = 1'b1;
      dma_data_i = mem[mem_addr[addr_width-1:2] + block_words - fill_left];
      fill_left--;
    end else if (dma_req_v_o) begin
      dma_req_yumi_i = 1'b1;
      mem_write = dma_req_write_o;
      mem_addr = dma_req_addr_o;
    end
  end

  initial begin
    clk_i = 1'b0;
    reset_i = 1'b1;
    v_i = 1'b0;
    we_i = 1'b0;
    addr_i = '0;
    wdata_i = '0;
    yumi_i = 1'b0;
    dma_req_yumi_i = 1'b0;
    dma_data_i = '0;
    dma_data_v_i = 1'b0;
    mem_write = 1'b0;
    mem_addr = '0;
    evict_left = 0;
    fill_left = 0;
    read_reqs = 0;
    write_reqs = 0;
    seed = 32'h9c6bbc22;
    tests = 0;
    failed = 0;
    errors = 0;
    timed_out = 1'b0;
    // high half fixed and low half the word's byte address
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = {16'h5A00, 16'(i * 4)};
    end
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    tests++;
    check_value("ready_o", ready_o, 1);
    check_value("v_o", v_o, 0);
    check_value("dma_req_v_o", dma_req_v_o, 0);
    check_value("dma_data_v_o", dma_data_v_o, 0);
    if (errors == 0) begin
      $display("test %0d: reset state ok", tests);
    end else begin
      failed++;
      $display("test %0d: reset state FAILED", tests);
    end

    fd = $fopen("sim/cache_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/cache_testdata.txt");
      errors++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = '0;
        if ($fgets(line, fd) != 0) begin
          if ($sscanf(line, "%h %h %h %h %h %h", f_op, f_miss, f_addr, f_wdata,
                      f_rdata, f_wb) == 6) begin
            run_access(f_op, f_miss, f_addr, f_wdata, f_rdata, f_wb);
          end
        end
      end
      $fclose(fd);
    end

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests, tests - failed, failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/cache_testdata.txt */
# columns: op (0 load, 1 store), miss (1 when a block fill is expected), byte address,
# store data, expected response data, expected writeback block address (ffff for none)
# cold load miss in set 0, then hits
0 1 0104 00000000 5a000104 ffff
0 0 0104 00000000 5a000104 ffff
0 0 010c 00000000 5a00010c ffff
# stores to the resident block, words stay independent
1 0 0108 deadbeef 00000000 ffff
0 0 0108 00000000 deadbeef ffff
1 0 0104 11112222 00000000 ffff
0 0 0108 00000000 deadbeef ffff
0 0 0104 00000000 11112222 ffff
0 0 010c 00000000 5a00010c ffff
# tags a0, b0, c0, d0 fill set 5, c0 gets two stored words
0 1 a050 00000000 5a00a050 ffff
0 1 b054 00000000 5a00b054 ffff
1 1 c050 cc000000 00000000 ffff
1 0 c05c cc00000c 00000000 ffff
0 1 d058 00000000 5a00d058 ffff
# touch a0 so the tree points at c0
0 0 a05c 00000000 5a00a05c ffff
# e0 evicts dirty c0
0 1 e054 00000000 5a00e054 c050
# c0 refills over clean b0 with its stored words
0 1 c050 00000000 cc000000 ffff
0 0 c05c 00000000 cc00000c ffff
0 0 c054 00000000 5a00c054 ffff
0 0 e058 00000000 5a00e058 ffff
# store miss into set 2, then read back
1 1 3f28 12345678 00000000 ffff
0 0 3f28 00000000 12345678 ffff
0 0 3f24 00000000 5a003f24 ffff

/* list.f */
design/cache_pkg.sv
design/cache_way.sv
design/cache_req_stage.sv
design/cache_hit_select.sv
design/cache_miss_dma.sv
design/cache_top.sv
sim/tb_cache.sv

/* Bender.yml */
package:
  name: cache

sources:
  - design/cache_pkg.sv
  - design/cache_way.sv
  - design/cache_req_stage.sv
  - design/cache_hit_select.sv
  - design/cache_miss_dma.sv
  - design/cache_top.sv
  - target: test
    files:
      - sim/tb_cache.sv
